//--- src/routerPkg.sv
package routerPkg;

	// Mesh coordinates of a node
	localparam int rowWidth = 2;
	localparam int columnWidth = 2;

	// Cache bank and payload sizes
	localparam int bankAddrWidth = 6;
	localparam int dataWidth = 16;

	// Four neighbour outputs plus the local cache bank
	localparam int portCount = 5;

	// Bit positions within a port mask
	localparam int northPort = 0;
	localparam int southPort = 1;
	localparam int eastPort = 2;
	localparam int westPort = 3;
	localparam int localPort = 4;

	// Rows grow southward, columns grow eastward
	typedef logic [rowWidth-1:0] rowAddrT;
	typedef logic [columnWidth-1:0] columnAddrT;

	// Node address, row in the upper bits and column in the lower bits
	typedef logic [rowWidth+columnWidth-1:0] netAddrT;

	typedef logic [bankAddrWidth-1:0] bankAddrT;
	typedef logic [dataWidth-1:0] dataT;

	// One bit per output, indexed by the port positions above
	typedef logic [portCount-1:0] portMaskT;

	// Target node plus the address inside that node's bank
	typedef struct packed {
		netAddrT node;
		bankAddrT bank;
	} destAddrT;

	// Packet is valid when read or write is set
	typedef struct packed {
		destAddrT destination;
		netAddrT requester;
		logic read;
		logic write;
		dataT data;
	} packetT;

endpackage

//--- src/inputStage.sv
`timescale 1ns/1ps

module inputStage (
	input logic clk,
	input logic reset,
	input routerPkg::netAddrT localAddress,
	input routerPkg::packetT packetIn,
	output routerPkg::packetT bufferedPacket,
	output routerPkg::portMaskT portSelect
);

	import routerPkg::*;

	// Split addresses into mesh coordinates
	rowAddrT localRow;
	columnAddrT localColumn;
	rowAddrT destRow;
	columnAddrT destColumn;

	logic packetValid;
	logic isLocal;
	portMaskT nextSelect;

	assign localRow = localAddress[columnWidth +: rowWidth];
	assign localColumn = localAddress[columnWidth-1:0];
	assign destRow = packetIn.destination.node[columnWidth +: rowWidth];
	assign destColumn = packetIn.destination.node[columnWidth-1:0];

	assign packetValid = packetIn.read | packetIn.write;
	assign isLocal = (packetIn.destination.node == localAddress);

	// Row first, then column
	always_comb begin
		nextSelect = '0;
		if (packetValid) begin
			if (isLocal) begin
				nextSelect[localPort] = 1'b1;
			end else if (destRow > localRow) begin
				nextSelect[southPort] = 1'b1;
			end else if (destRow < localRow) begin
				nextSelect[northPort] = 1'b1;
			end else if (destColumn > localColumn) begin
				// Right row already, move along it
				nextSelect[eastPort] = 1'b1;
			end else if (destColumn < localColumn) begin
				nextSelect[westPort] = 1'b1;
			end
		end
	end

	// Packet and its selection leave together after one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			bufferedPacket <= '0;
			portSelect <= '0;
		end else begin
			bufferedPacket <= packetIn;
			portSelect <= nextSelect;
		end
	end

endmodule

//--- src/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter (
	input logic clk,
	input logic reset,
	input logic [3:0] requests,
	input routerPkg::packetT [3:0] candidates,
	output routerPkg::packetT packetOut,
	output logic contentionError
);

	import routerPkg::*;

	// Number of inputs asking for this output
	logic [2:0] requestCount;
	logic [1:0] grantIndex;
	logic singleRequest;
	logic multipleRequests;
	packetT selectedPacket;

	// Request order is north, south, east, west
	always_comb begin
		requestCount = '0;
		grantIndex = '0;
		for (int i = 0; i < 4; i++) begin
			if (requests[i]) begin
				requestCount = requestCount + 3'd1;
				grantIndex = i[1:0];
			end
		end
	end

	assign singleRequest = (requestCount == 3'd1);
	assign multipleRequests = (requestCount > 3'd1);

	// Only meaningful when exactly one input asks
	assign selectedPacket = candidates[grantIndex];

	always_ff @(posedge clk) begin
		if (reset) begin
			packetOut <= '0;
			contentionError <= 1'b0;
		end else if (singleRequest) begin
			packetOut <= selectedPacket;
			contentionError <= 1'b0;
		end else begin
			// Idle or contention, the packets are dropped
			packetOut.read <= 1'b0;
			packetOut.write <= 1'b0;
			contentionError <= multipleRequests;
		end
	end

endmodule

//--- src/meshRouter.sv
`timescale 1ns/1ps

module meshRouter (
	input logic clk,
	input logic reset,
	input routerPkg::netAddrT localAddress,

	input routerPkg::packetT northIn,
	input routerPkg::packetT southIn,
	input routerPkg::packetT eastIn,
	input routerPkg::packetT westIn,

	output routerPkg::packetT northOut,
	output routerPkg::packetT southOut,
	output routerPkg::packetT eastOut,
	output routerPkg::packetT westOut,

	// Cache bank port
	output routerPkg::bankAddrT cacheAddress,
	output routerPkg::dataT cacheDataIn,
	output logic memRead,
	output logic memWrite,

	output routerPkg::portMaskT contentionError
);

	import routerPkg::*;

	// Registered packets and selections, indexed by input port
	packetT [3:0] bufferedPackets;
	portMaskT [3:0] portSelects;

	// Select bits regrouped per output
	logic [portCount-1:0][3:0] outputRequests;
	packetT [portCount-1:0] arbiterPackets;

	inputStage inNorth (
		.clk(clk),
		.reset(reset),
		.localAddress(localAddress),
		.packetIn(northIn),
		.bufferedPacket(bufferedPackets[northPort]),
		.portSelect(portSelects[northPort])
	);

	inputStage inSouth (
		.clk(clk),
		.reset(reset),
		.localAddress(localAddress),
		.packetIn(southIn),
		.bufferedPacket(bufferedPackets[southPort]),
		.portSelect(portSelects[southPort])
	);

	inputStage inEast (
		.clk(clk),
		.reset(reset),
		.localAddress(localAddress),
		.packetIn(eastIn),
		.bufferedPacket(bufferedPackets[eastPort]),
		.portSelect(portSelects[eastPort])
	);

	inputStage inWest (
		.clk(clk),
		.reset(reset),
		.localAddress(localAddress),
		.packetIn(westIn),
		.bufferedPacket(bufferedPackets[westPort]),
		.portSelect(portSelects[westPort])
	);

	// One arbiter per output, local cache included
	for (genvar p = 0; p < portCount; p++) begin : gOutput
		// Transpose select masks into this output's request vector
		for (genvar s = 0; s < 4; s++) begin : gGather
			assign outputRequests[p][s] = portSelects[s][p];
		end

		outputArbiter arbiter (
			.clk(clk),
			.reset(reset),
			.requests(outputRequests[p]),
			.candidates(bufferedPackets),
			.packetOut(arbiterPackets[p]),
			.contentionError(contentionError[p])
		);
	end

	assign northOut = arbiterPackets[northPort];
	assign southOut = arbiterPackets[southPort];
	assign eastOut = arbiterPackets[eastPort];
	assign westOut = arbiterPackets[westPort];

	// Local packet drives the cache bank directly
	assign cacheAddress = arbiterPackets[localPort].destination.bank;
	assign cacheDataIn = arbiterPackets[localPort].data;
	assign memRead = arbiterPackets[localPort].read;
	assign memWrite = arbiterPackets[localPort].write;

endmodule

//--- tb/outputArbiter_props.sv
`timescale 1ns/1ps

module outputArbiterProps (
	input logic clk,
	input logic reset,
	input logic [3:0] requests,
	input routerPkg::packetT packetOut,
	input logic contentionError
);

	// A single request or none is never contention
	property noFalseContention;
		@(posedge clk) disable iff (reset)
		($countones(requests) < 2) |=> !contentionError;
	endproperty

	// Competing requests are flagged one cycle later
	property contentionFlagged;
		@(posedge clk) disable iff (reset)
		($countones(requests) > 1) |=> contentionError;
	endproperty

	// Packets lost to contention leave the output invalid
	property contentionDropsPacket;
		@(posedge clk) disable iff (reset)
		($countones(requests) > 1) |=> !(packetOut.read || packetOut.write);
	endproperty

	property resetClearsOutput;
		@(posedge clk)
		reset |=> !packetOut.read && !packetOut.write && !contentionError;
	endproperty

	assert property (noFalseContention)
		else $error("contentionError set with fewer than two requests");
	assert property (contentionFlagged)
		else $error("contentionError missing after competing requests");
	assert property (contentionDropsPacket)
		else $error("valid packet on output after competing requests");
	assert property (resetClearsOutput)
		else $error("arbiter output not cleared by reset");

endmodule

bind outputArbiter outputArbiterProps arbiterChecks (
	.clk(clk),
	.reset(reset),
	.requests(requests),
	.packetOut(packetOut),
	.contentionError(contentionError)
);

//--- tb/meshRouterTb.sv
`timescale 1ns/1ps

module meshRouterTb;

	import routerPkg::*;

	// Whole run is well under 200 cycles
	localparam int maxCycles = 2000;
	localparam int columns = 1 << columnWidth;
	localparam int burstLength = 6;
	// Row 1, column 1, so every direction has a neighbour
	localparam netAddrT homeAddress = 4'b0101;

	logic clk;
	logic reset;
	netAddrT localAddress;
	packetT northIn;
	packetT southIn;
	packetT eastIn;
	packetT westIn;
	packetT northOut;
	packetT southOut;
	packetT eastOut;
	packetT westOut;
	bankAddrT cacheAddress;
	dataT cacheDataIn;
	logic memRead;
	logic memWrite;
	portMaskT contentionError;

	integer seed = 32'hde72_05db;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	meshRouter i_dut (
		.clk(clk),
		.reset(reset),
		.localAddress(localAddress),
		.northIn(northIn),
		.southIn(southIn),
		.eastIn(eastIn),
		.westIn(westIn),
		.northOut(northOut),
		.southOut(southOut),
		.eastOut(eastOut),
		.westOut(westOut),
		.cacheAddress(cacheAddress),
		.cacheDataIn(cacheDataIn),
		.memRead(memRead),
		.memWrite(memWrite),
		.contentionError(contentionError)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == maxCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", maxCycles);
			$display("Errors found");
			$finish;
		end
	end

	task automatic checkPacket(string what, packetT actual, packetT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkCacheAccess(bankAddrT actualAddr, bankAddrT expectedAddr,
			dataT actualData, dataT expectedData, logic actualRead, logic expectedRead,
			logic actualWrite, logic expectedWrite);
		checkCount++;
		if (actualAddr !== expectedAddr || actualData !== expectedData
				|| actualRead !== expectedRead || actualWrite !== expectedWrite) begin
			errorCount++;
			$display("[FAIL] %0t: cache access addr %h data %h rd %b wr %b, expected %h %h %b %b",
				$time, actualAddr, actualData, actualRead, actualWrite,
				expectedAddr, expectedData, expectedRead, expectedWrite);
		end
	endtask

	task automatic checkContention(portMaskT actual, portMaskT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t: contention %b, expected %b", $time, actual, expected);
		end
	endtask

	task automatic checkValidPorts(portMaskT actual, portMaskT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t: valid outputs %b, expected %b", $time, actual, expected);
		end
	endtask

	// Expected output for one packet, straight from the routing rule
	function automatic portMaskT predictRoute(netAddrT dest, netAddrT here, logic valid);
		int destRow;
		int destColumn;
		int hereRow;
		int hereColumn;
		portMaskT route;
		destRow = int'(dest) / columns;
		destColumn = int'(dest) % columns;
		hereRow = int'(here) / columns;
		hereColumn = int'(here) % columns;
		route = '0;
		if (valid) begin
			if (destRow == hereRow && destColumn == hereColumn) begin
				route[localPort] = 1'b1;
			end else if (destRow > hereRow) begin
				route[southPort] = 1'b1;
			end else if (destRow < hereRow) begin
				route[northPort] = 1'b1;
			end else if (destColumn > hereColumn) begin
				route[eastPort] = 1'b1;
			end else begin
				route[westPort] = 1'b1;
			end
		end
		return route;
	endfunction

	function automatic portMaskT portBit(int port);
		portMaskT mask;
		mask = '0;
		mask[port] = 1'b1;
		return mask;
	endfunction

	function automatic int routeIndex(portMaskT route);
		int index;
		index = -1;
		for (int i = 0; i < portCount; i++) begin
			if (route[i]) begin
				index = i;
			end
		end
		return index;
	endfunction

	// Random payload, exactly one of read or write
	function automatic packetT randomPacket(netAddrT dest);
		packetT p;
		logic [31:0] bits;
		bits = $random(seed);
		p.destination.node = dest;
		p.destination.bank = bits[5:0];
		p.requester = bits[9:6];
		p.data = bits[25:10];
		p.read = bits[26];
		p.write = !bits[26];
		return p;
	endfunction

	function automatic portMaskT observedValid();
		portMaskT mask;
		mask[northPort] = northOut.read | northOut.write;
		mask[southPort] = southOut.read | southOut.write;
		mask[eastPort] = eastOut.read | eastOut.write;
		mask[westPort] = westOut.read | westOut.write;
		mask[localPort] = memRead | memWrite;
		return mask;
	endfunction

	function automatic packetT outputPacket(int port);
		packetT p;
		case (port)
			northPort: p = northOut;
			southPort: p = southOut;
			eastPort: p = eastOut;
			default: p = westOut;
		endcase
		return p;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic driveIdle();
		northIn = '0;
		southIn = '0;
		eastIn = '0;
		westIn = '0;
	endtask

	task automatic drivePort(int port, packetT p);
		case (port)
			northPort: northIn = p;
			southPort: southIn = p;
			eastPort: eastIn = p;
			default: westIn = p;
		endcase
	endtask

	// One packet in, then wait out the two-cycle latency
	task automatic sendSingle(int port, packetT p);
		drivePort(port, p);
		nextCycle();
		driveIdle();
		nextCycle();
	endtask

	task automatic checkDelivery(int port, packetT expected);
		if (port == localPort) begin
			checkCacheAccess(cacheAddress, expected.destination.bank, cacheDataIn,
				expected.data, memRead, expected.read, memWrite, expected.write);
		end else begin
			checkPacket($sformatf("output %0d", port), outputPacket(port), expected);
		end
	endtask

	task automatic checkPortFlags(portMaskT expectValid, portMaskT expectContention);
		checkValidPorts(observedValid(), expectValid);
		checkContention(contentionError, expectContention);
	endtask

	task automatic testResetState();
		reset = 1'b1;
		repeat (5) nextCycle();
		reset = 1'b0;
		for (int port = 0; port < 4; port++) begin
			checkPacket($sformatf("output %0d after reset", port), outputPacket(port), '0);
		end
		checkPortFlags('0, '0);
	endtask

	task automatic testLocalDelivery();
		packetT p;
		localAddress = homeAddress;
		for (int port = 0; port < 4; port++) begin
			for (int kind = 0; kind < 2; kind++) begin
				p = randomPacket(homeAddress);
				p.read = (kind == 0);
				p.write = (kind == 1);
				sendSingle(port, p);
				checkDelivery(localPort, p);
				checkPortFlags(portBit(localPort), '0);
			end
		end
	endtask

	task automatic testRandomRouting();
		packetT p;
		portMaskT route;
		logic [31:0] bits;
		int port;
		repeat (40) begin
			bits = $random(seed);
			port = int'(bits[1:0]);
			localAddress = bits[7:4];
			p = randomPacket(bits[11:8]);
			route = predictRoute(p.destination.node, localAddress, p.read | p.write);
			sendSingle(port, p);
			checkDelivery(routeIndex(route), p);
			checkPortFlags(route, '0);
		end
		localAddress = homeAddress;
	endtask

	task automatic testParallelTraffic();
		packetT toSouth;
		packetT toNorth;
		packetT toEast;
		packetT toLocal;
		localAddress = homeAddress;
		toSouth = randomPacket(4'b1001);
		toNorth = randomPacket(4'b0010);
		toEast = randomPacket(4'b0111);
		toLocal = randomPacket(homeAddress);
		northIn = toSouth;
		southIn = toNorth;
		eastIn = toLocal;
		westIn = toEast;
		nextCycle();
		driveIdle();
		nextCycle();
		checkDelivery(southPort, toSouth);
		checkDelivery(northPort, toNorth);
		checkDelivery(eastPort, toEast);
		checkDelivery(localPort, toLocal);
		checkPortFlags(portBit(southPort) | portBit(northPort) | portBit(eastPort)
			| portBit(localPort), '0);
	endtask

	// Back-to-back packets east to west, checked as they stream out
	task automatic testBurst();
		packetT burst [burstLength];
		localAddress = homeAddress;
		for (int i = 0; i < burstLength; i++) begin
			burst[i] = randomPacket(4'b0100);
			burst[i].data = dataT'(16'hb000 + i);
		end
		for (int i = 0; i < burstLength + 2; i++) begin
			if (i < burstLength) begin
				drivePort(eastPort, burst[i]);
			end else begin
				driveIdle();
			end
			if (i >= 2) begin
				checkDelivery(westPort, burst[i-2]);
				checkPortFlags(portBit(westPort), '0);
			end
			nextCycle();
		end
	endtask

	task automatic testContention();
		packetT third;
		localAddress = homeAddress;
		third = randomPacket(4'b0000);
		northIn = randomPacket(4'b0111);
		southIn = randomPacket(4'b0110);
		westIn = third;
		nextCycle();
		driveIdle();
		nextCycle();
		checkDelivery(northPort, third);
		checkPortFlags(portBit(northPort), portBit(eastPort));
		// Two requests for the cache bank
		northIn = randomPacket(homeAddress);
		eastIn = randomPacket(homeAddress);
		nextCycle();
		driveIdle();
		nextCycle();
		checkPortFlags('0, portBit(localPort));
		nextCycle();
		checkPortFlags('0, '0);
	endtask

	task automatic testIdleInputs();
		packetT p;
		localAddress = homeAddress;
		for (int port = 0; port < 4; port++) begin
			p = randomPacket(homeAddress);
			p.read = 1'b0;
			p.write = 1'b0;
			drivePort(port, p);
		end
		repeat (3) begin
			nextCycle();
			checkPortFlags('0, '0);
		end
		driveIdle();
	endtask

	initial begin
		reset = 1'b1;
		localAddress = homeAddress;
		driveIdle();
		testResetState();
		testLocalDelivery();
		testRandomRouting();
		testParallelTraffic();
		testBurst();
		testContention();
		testIdleInputs();
		$display("Checks: %0d, failed: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- sim.f
src/routerPkg.sv
src/inputStage.sv
src/outputArbiter.sv
src/meshRouter.sv
tb/outputArbiter_props.sv
tb/meshRouterTb.sv

//--- run.sh
#!/bin/sh
# Build and run the mesh router testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module meshRouterTb --Mdir "$buildDir" -o simv -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

# A failed assertion stops the simulator with a nonzero status
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Errors found" "$logFile"; then
	echo "Simulation reported failures"
	exit 1
fi

# Missing summary means the run ended early
if ! grep -q "No errors" "$logFile"; then
	echo "Simulation ended without a summary"
	exit 1
fi

echo "Simulation passed"
exit 0
